/* glb_pkg.sv */
// Shared definitions for the global buffer bank behind an AXI4-Lite port.
// Holds bank geometry, bus widths, response codes and the controller states.
// Import it by wildcard in the header of any module that needs it.

package glb_pkg;

    // Bank geometry.
    localparam int BANK_DATA_WIDTH = 64;   // One word, eight bytes.
    localparam int BANK_ADDR_WIDTH = 12;   // Byte address, 4 KiB bank.
    localparam int BANK_BYTE_OFFSET = 3;   // Byte select bits within a word.
    localparam int BANK_WORD_ADDR_WIDTH = BANK_ADDR_WIDTH - BANK_BYTE_OFFSET;
    localparam int BANK_NUM_WORDS = 1 << BANK_WORD_ADDR_WIDTH;  // 512 words.

    // AXI4-Lite bus.
    localparam int AXI_ADDR_WIDTH = 16;
    localparam int AXI_STRB_WIDTH = BANK_DATA_WIDTH / 8;  // One strobe per byte.

    // Response codes.
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // Controller FSM.
    typedef enum logic [2:0] {
        CTRL_IDLE,        // Waiting for a request.
        CTRL_WRITE,       // Write strobe to the bank.
        CTRL_READ,        // Read strobe to the bank.
        CTRL_READ_WAIT,   // Waiting for rd_valid.
        CTRL_WRITE_RESP,  // bvalid held until bready.
        CTRL_READ_RESP    // rvalid held until rready.
    } ctrl_state_e;

endpackage

/* glb_bank_if.sv */
// Link between the AXI4-Lite controller and the bank core.
// The controller issues single-cycle ren or wen strobes with a byte address;
// the core answers reads two cycles later with rd_valid and data_out.

`timescale 1ns/10ps

interface glb_bank_if import glb_pkg::*; ();

    logic                       ren;       // Read strobe.
    logic                       wen;       // Write strobe.
    logic [BANK_ADDR_WIDTH-1:0] addr;      // Bank byte address.
    logic [BANK_DATA_WIDTH-1:0] data_in;   // Write data.
    logic [BANK_DATA_WIDTH-1:0] bit_sel;   // Per-bit write mask, high = write.
    logic [BANK_DATA_WIDTH-1:0] data_out;  // Last read word.
    logic                       rd_valid;  // data_out is fresh this cycle.

    // Controller side.
    modport ctrl (
        output ren, wen, addr, data_in, bit_sel,
        input  data_out, rd_valid
    );

    // Bank core side.
    modport mem (
        input  ren, wen, addr, data_in, bit_sel,
        output data_out, rd_valid
    );

endinterface

/* glb_bank_sram.sv */
// Behavioral model of the bank SRAM macro, 512 words by 64 bits.
// Control pins are active low, as on the real macro.
// Writes take effect at the clock edge; reads return q two edges later.

`timescale 1ns/10ps

module glb_bank_sram import glb_pkg::*; (
    input  logic                            clk,
    input  logic                            ceb,   // Chip enable, active low.
    input  logic                            web,   // Write enable, active low.
    input  logic [BANK_WORD_ADDR_WIDTH-1:0] a,     // Word address.
    input  logic [BANK_DATA_WIDTH-1:0]      d,
    input  logic [BANK_DATA_WIDTH-1:0]      bweb,  // Bit write enable, active low.
    output logic [BANK_DATA_WIDTH-1:0]      q
);

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_NUM_WORDS];
    logic [BANK_DATA_WIDTH-1:0] q_stage;  // First read stage.

    // Array write, masked per bit.
    always_ff @(posedge clk) begin
        if (!ceb && !web) begin
            mem[a] <= (mem[a] & bweb) | (d & ~bweb);  // Keep bits with bweb high.
        end
    end

    // Array read into the first stage.
    always_ff @(posedge clk) begin
        if (!ceb && web) begin
            q_stage <= mem[a];
        end
    end

    // Output register.
    // Runs every cycle; the bank core only samples it on rd_valid.
    always_ff @(posedge clk) begin
        q <= q_stage;
    end

endmodule

/* glb_bank_memory.sv */
// Bank core around the SRAM macro.
// Converts byte addresses to word addresses and drives the active-low pins.
// A read strobe returns rd_valid and the word two cycles later;
// between reads data_out keeps showing the last word read.

`timescale 1ns/10ps

module glb_bank_memory import glb_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    glb_bank_if.mem  bank
);

    logic                            sram_ceb;
    logic                            sram_web;
    logic [BANK_WORD_ADDR_WIDTH-1:0] sram_addr;
    logic [BANK_DATA_WIDTH-1:0]      sram_bweb;
    logic [BANK_DATA_WIDTH-1:0]      sram_q;
    logic                            ren_d1;
    logic                            ren_d2;
    logic [BANK_DATA_WIDTH-1:0]      data_out_c;
    logic [BANK_DATA_WIDTH-1:0]      data_out_hold;  // Previous data_out.

    // Macro pin mapping.
    assign sram_ceb = ~(bank.ren | bank.wen);            // Enabled on any access.
    assign sram_web = ~bank.wen;
    assign sram_addr = bank.addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];  // Drop byte bits.
    assign sram_bweb = ~bank.bit_sel;

    glb_bank_sram u_sram (
        .clk  (clk),
        .ceb  (sram_ceb),
        .web  (sram_web),
        .a    (sram_addr),
        .d    (bank.data_in),
        .bweb (sram_bweb),
        .q    (sram_q)
    );

    // Read strobe delay matches the macro latency.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ren_d1 <= 1'b0;
            ren_d2 <= 1'b0;
            data_out_hold <= '0;  // Zero until the first read.
        end else begin
            ren_d1 <= bank.ren;
            ren_d2 <= ren_d1;
            data_out_hold <= data_out_c;
        end
    end

    // Fresh macro word on rd_valid, else hold.
    assign data_out_c = ren_d2 ? sram_q : data_out_hold;
    assign bank.data_out = data_out_c;
    assign bank.rd_valid = ren_d2;

endmodule

/* glb_axil_bank_ctrl.sv */
// AXI4-Lite slave that serves one transaction at a time on the bank.
// Reads and writes alternate when both are pending; a read wins first.
// Out-of-range addresses answer SLVERR and never reach the bank.
// Responses are held until the master accepts them.

`timescale 1ns/10ps

module glb_axil_bank_ctrl import glb_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [AXI_ADDR_WIDTH-1:0]  awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [BANK_DATA_WIDTH-1:0] wdata,
    input  logic [AXI_STRB_WIDTH-1:0]  wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [AXI_ADDR_WIDTH-1:0]  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [BANK_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    glb_bank_if.ctrl                   bank
);

    ctrl_state_e                state;
    ctrl_state_e                state_next;
    logic                       wr_pend;
    logic                       rd_pend;
    logic                       take_rd;      // Read accepted this cycle.
    logic                       take_wr;      // Write accepted this cycle.
    logic                       last_rd;      // Last served kind was a read.
    logic [AXI_ADDR_WIDTH-1:0]  req_addr;
    logic                       req_in_range;
    logic [BANK_ADDR_WIDTH-1:0] addr_q;
    logic                       in_range_q;
    logic [BANK_DATA_WIDTH-1:0] wdata_q;
    logic [AXI_STRB_WIDTH-1:0]  wstrb_q;
    logic [BANK_DATA_WIDTH-1:0] bit_sel;

    // Arbitration.
    assign wr_pend = awvalid && wvalid;  // Need both channels.
    assign rd_pend = arvalid;
    assign take_rd = (state == CTRL_IDLE) && rd_pend && (!wr_pend || !last_rd);
    assign take_wr = (state == CTRL_IDLE) && wr_pend && !take_rd;

    assign arready = take_rd;
    assign awready = take_wr;  // Together with wready.
    assign wready = take_wr;

    // Range decode on the accepted address.
    assign req_addr = take_rd ? araddr : awaddr;
    assign req_in_range = (req_addr[AXI_ADDR_WIDTH-1:BANK_ADDR_WIDTH] == '0);

    always_comb begin
        state_next = state;
        case (state)
            CTRL_IDLE: begin
                if (take_rd) begin
                    state_next = CTRL_READ;
                end else if (take_wr) begin
                    state_next = CTRL_WRITE;
                end
            end
            CTRL_WRITE:      state_next = CTRL_WRITE_RESP;
            CTRL_READ:       state_next = in_range_q ? CTRL_READ_WAIT : CTRL_READ_RESP;
            CTRL_READ_WAIT:  if (bank.rd_valid) state_next = CTRL_READ_RESP;
            CTRL_WRITE_RESP: if (bready) state_next = CTRL_IDLE;
            CTRL_READ_RESP:  if (rready) state_next = CTRL_IDLE;
            default:         state_next = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= CTRL_IDLE;
            last_rd <= 1'b0;  // So the first tie goes to the read.
        end else begin
            state <= state_next;
            if (take_rd) begin
                last_rd <= 1'b1;
            end else if (take_wr) begin
                last_rd <= 1'b0;
            end
        end
    end

    // Request and response payload.
    always_ff @(posedge clk) begin
        if (take_rd || take_wr) begin
            addr_q <= req_addr[BANK_ADDR_WIDTH-1:0];
            in_range_q <= req_in_range;
        end
        if (take_wr) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
            bresp <= req_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
        if (state == CTRL_READ && !in_range_q) begin
            rdata <= '0;  // Nothing read.
            rresp <= AXI_RESP_SLVERR;
        end else if (state == CTRL_READ_WAIT && bank.rd_valid) begin
            rdata <= bank.data_out;
            rresp <= AXI_RESP_OKAY;
        end
    end

    // Byte strobes widened to bit mask.
    always_comb begin
        for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
            bit_sel[8*i +: 8] = {8{wstrb_q[i]}};
        end
    end

    // Bank strobes, in range only.
    assign bank.ren = (state == CTRL_READ) && in_range_q;
    assign bank.wen = (state == CTRL_WRITE) && in_range_q;
    assign bank.addr = addr_q;
    assign bank.data_in = wdata_q;
    assign bank.bit_sel = bit_sel;

    assign bvalid = (state == CTRL_WRITE_RESP);
    assign rvalid = (state == CTRL_READ_RESP);

endmodule

/* glb_bank_top.sv */
// Top level of one global buffer bank with an AXI4-Lite slave port.
// Joins the bus controller and the bank core over a bank interface.

`timescale 1ns/10ps

module glb_bank_top import glb_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [AXI_ADDR_WIDTH-1:0]  awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [BANK_DATA_WIDTH-1:0] wdata,
    input  logic [AXI_STRB_WIDTH-1:0]  wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [AXI_ADDR_WIDTH-1:0]  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [BANK_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    glb_bank_if bank_bus ();  // Controller to core.

    glb_axil_bank_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bank    (bank_bus)
    );

    glb_bank_memory u_memory (
        .clk   (clk),
        .reset (reset),
        .bank  (bank_bus)
    );

endmodule

/* glb_bank_chk.sv */
// Concurrent protocol checks on the AXI4-Lite side of the bank top level.
// Bound into every glb_bank_top instance; failures count in fail_count.

`timescale 1ns/10ps

module glb_bank_chk import glb_pkg::*; (
    input logic                       clk,
    input logic                       reset,
    input logic                       awvalid, wvalid,
    input logic                       awready, wready, arready,
    input logic                       bvalid, bready, rvalid, rready,
    input logic [1:0]                 bresp, rresp,
    input logic [BANK_DATA_WIDTH-1:0] rdata
);

    int fail_count = 0;  // Read by the testbench.

    // Write response held with a stable code until bready.
    bresp_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("bvalid dropped or bresp changed before bready");
            fail_count++;
        end

    // Read response held with stable payload until rready.
    rresp_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
        else begin
            $error("rvalid dropped or read payload changed before rready");
            fail_count++;
        end

    // Address and data channels accepted together and only with both valid.
    aw_w_together: assert property (@(posedge clk) disable iff (reset)
        awready || wready |-> awready && wready && awvalid && wvalid)
        else begin
            $error("awready and wready not high together with both valids");
            fail_count++;
        end

    // Quiet bus while in reset.
    reset_quiet: assert property (@(posedge clk)
        reset |-> !(awready || wready || arready || bvalid || rvalid))
        else begin
            $error("ready or valid output high during reset");
            fail_count++;
        end

endmodule

bind glb_bank_top glb_bank_chk u_chk (.*);

/* glb_bank_tb.sv */
// Testbench for one global buffer bank behind an AXI4-Lite slave port.
// Bus tasks drive the five channels, a monitor keeps a shadow copy of the
// array and compares every response against it. Protocol assertions are
// bound in from a separate checker module.

`timescale 1ns/10ps

module glb_bank_tb import glb_pkg::*; ();

    localparam int TIMEOUT = 50;                     // Cycles per wait loop.
    localparam int BANK_SIZE = 1 << BANK_ADDR_WIDTH;  // Bytes.

    logic clk, reset;
    logic [AXI_ADDR_WIDTH-1:0]  awaddr, araddr;
    logic [BANK_DATA_WIDTH-1:0] wdata, rdata;
    logic [AXI_STRB_WIDTH-1:0]  wstrb;
    logic [1:0]                 bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;

    logic [BANK_DATA_WIDTH-1:0] shadow [BANK_NUM_WORDS];  // Expected array contents.
    logic [AXI_ADDR_WIDTH-1:0]  mon_wr_addr, mon_rd_addr;  // Accepted addresses.
    logic [BANK_DATA_WIDTH-1:0] sim_rd [8], sim_wr [8], base_word;
    int errors, errors_at_start, tests_passed, tests_failed, bp_max;
    string test_name;

    glb_bank_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    // Expected word after a strobed write.
    function automatic logic [BANK_DATA_WIDTH-1:0] ref_merge(
        input logic [BANK_DATA_WIDTH-1:0] old_word,
        input logic [BANK_DATA_WIDTH-1:0] new_word,
        input logic [AXI_STRB_WIDTH-1:0]  strb);
        logic [BANK_DATA_WIDTH-1:0] result;
        result = old_word;
        for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
            if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];  // Strobed byte replaced.
        end
        return result;
    endfunction

    function automatic bit in_bank(input logic [AXI_ADDR_WIDTH-1:0] addr);
        return int'(addr) < BANK_SIZE;
    endfunction

    function automatic int total_errors();
        return errors + DUT.u_chk.fail_count;  // Assertion failures count too.
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_stall(input string what);
        $display("Timeout after %0d cycles in test %s: %s", TIMEOUT, test_name, what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // Random response back-pressure ending 2 ns after an edge.
    task automatic hold_off();
        int delay;
        delay = (bp_max > 0) ? $urandom_range(bp_max) : 0;
        repeat (delay + 1) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic axil_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                              input logic [BANK_DATA_WIDTH-1:0] data,
                              input logic [AXI_STRB_WIDTH-1:0] strb, output logic [1:0] resp);
        int cnt;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!awready && cnt < TIMEOUT);
        if (!awready) report_stall("write address and data never accepted");
        @(posedge clk);  // Transfer edge.
        #2;
        awvalid = 1'b0;
        wvalid = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!bvalid && cnt < TIMEOUT);
        if (!bvalid) report_stall("write response never arrived");
        hold_off();
        bready = 1'b1;
        @(negedge clk);
        resp = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [AXI_ADDR_WIDTH-1:0] addr,
                             output logic [BANK_DATA_WIDTH-1:0] data, output logic [1:0] resp);
        int cnt;
        araddr = addr;
        arvalid = 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!arready && cnt < TIMEOUT);
        if (!arready) report_stall("read address never accepted");
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!rvalid && cnt < TIMEOUT);
        if (!rvalid) report_stall("read data never arrived");
        hold_off();
        rready = 1'b1;
        @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    // Reads and writes over the bank, some reads right after a write.
    task automatic random_traffic(input int count);
        logic [AXI_ADDR_WIDTH-1:0]  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp;
        for (int n = 0; n < count; n++) begin
            addr = AXI_ADDR_WIDTH'($urandom_range(BANK_SIZE - 1));
            if ($urandom_range(1)) begin
                axil_write(addr, {$urandom, $urandom}, AXI_STRB_WIDTH'($urandom), resp);
                if ($urandom_range(1)) axil_read(addr, data, resp);  // Read after write.
            end else begin
                axil_read(addr, data, resp);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = total_errors();
    endtask

    task automatic end_test();
        if (total_errors() == errors_at_start) begin
            tests_passed++;
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, total_errors() - errors_at_start);
        end
    endtask

    // Monitor. Samples at the falling edge, where outputs are settled.
    always @(negedge clk) begin
        if (!reset) begin
            if (awready && wready) begin
                mon_wr_addr = awaddr;
                if (in_bank(awaddr)) begin
                    shadow[awaddr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET]] = ref_merge(
                        shadow[awaddr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET]], wdata, wstrb);
                end
            end
            if (arready) mon_rd_addr = araddr;
            if (bvalid && bready) begin
                check_value("bresp", in_bank(mon_wr_addr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR, bresp);
            end
            if (rvalid && rready) begin
                check_value("rresp", in_bank(mon_rd_addr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR, rresp);
                check_value("rdata", in_bank(mon_rd_addr) ?
                    shadow[mon_rd_addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET]] : '0, rdata);
            end
        end
    end

    initial begin
        logic [BANK_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp, resp_r, resp_w;
        logic [AXI_ADDR_WIDTH-1:0]  addr;
        void'($urandom(28110));
        reset = 1'b1;
        {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
        {araddr, arvalid, rready} = '0;
        {errors, tests_passed, tests_failed, bp_max} = '0;
        test_name = "preload";
        apply_reset();
        for (int w = 0; w < BANK_NUM_WORDS; w++) begin  // Known contents everywhere.
            axil_write(AXI_ADDR_WIDTH'(w << BANK_BYTE_OFFSET), {4{16'(w) ^ 16'h5AC3}}, '1, resp);
        end

        start_test("full_word");
        for (int i = 0; i < 8; i++) begin
            addr = AXI_ADDR_WIDTH'(i * 'h208);
            axil_write(addr, {$urandom, $urandom}, '1, resp);
            axil_read(addr, data, resp);
        end
        end_test();

        start_test("partial_strobe");
        for (int i = 0; i < 16; i++) begin
            addr = AXI_ADDR_WIDTH'($urandom_range(BANK_NUM_WORDS - 1) << BANK_BYTE_OFFSET);
            axil_write(addr, {$urandom, $urandom}, AXI_STRB_WIDTH'($urandom), resp);
            axil_read(addr, data, resp);
        end
        end_test();

        start_test("out_of_range");
        for (int i = 0; i < 8; i++) begin
            addr = AXI_ADDR_WIDTH'($urandom_range(16'hFFFF, BANK_SIZE));
            axil_write(addr, {$urandom, $urandom}, '1, resp);
            axil_read(addr, data, resp);
            axil_read(addr & AXI_ADDR_WIDTH'(BANK_SIZE - 1), data, resp);  // Alias untouched.
        end
        end_test();

        start_test("random_mixed");
        random_traffic(200);
        end_test();

        start_test("back_pressure");
        bp_max = 4;
        random_traffic(40);
        bp_max = 0;
        end_test();

        // Both kinds pending at once. Read first after reset, then alternate.
        start_test("simultaneous");
        base_word = {$urandom, $urandom};
        axil_write(16'h0348, base_word, '1, resp);
        for (int k = 0; k < 8; k++) sim_wr[k] = {$urandom, $urandom};
        apply_reset();
        fork
            for (int k = 0; k < 8; k++) axil_read(16'h0348, sim_rd[k], resp_r);
            for (int k = 0; k < 8; k++) axil_write(16'h0348, sim_wr[k], '1, resp_w);
        join
        for (int k = 0; k < 8; k++) begin
            check_value($sformatf("read %0d order", k), (k == 0) ? base_word : sim_wr[k-1],
                        sim_rd[k]);
        end
        end_test();

        $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, DUT.u_chk.fail_count);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
glb_pkg.sv
glb_bank_if.sv
glb_bank_sram.sv
glb_bank_memory.sv
glb_axil_bank_ctrl.sv
glb_bank_top.sv
glb_bank_chk.sv
glb_bank_tb.sv

/* Bender.yml */
package:
  name: glb_bank

sources:
  # RTL in compile order.
  - files:
      - glb_pkg.sv
      - glb_bank_if.sv
      - glb_bank_sram.sv
      - glb_bank_memory.sv
      - glb_axil_bank_ctrl.sv
      - glb_bank_top.sv

  # Testbench and bound checker.
  - target: test
    files:
      - glb_bank_chk.sv
      - glb_bank_tb.sv
